/* axi4_w_defs.svh */
// Widths and queue depths for the W buffer; all RTL files and the package share these values
`ifndef AXI4_W_DEFS_SVH
`define AXI4_W_DEFS_SVH

// AXI4 W channel widths
`define AXI_DATA_WIDTH 32
`define AXI_ID_WIDTH   4
`define AXI_USER_WIDTH 4

// Input beat FIFO depth, the slave side stalls once this many beats wait
`define W_FIFO_DEPTH 4

// Decision FIFO depth
// Input stall is raised while this many decisions are queued
`define L1_FIFO_DEPTH 8

`endif

/* axi4_w_pkg.sv */
// Beat and decision types; the strobe width is fixed to one bit per data byte
`default_nettype none

`include "axi4_w_defs.svh"

package axi4_w_pkg;

  // One W beat as it is stored in the input FIFO
  typedef struct packed {
    logic [`AXI_DATA_WIDTH-1:0]   data;
    logic [`AXI_DATA_WIDTH/8-1:0] strb;
    logic [`AXI_USER_WIDTH-1:0]   user;
    logic                         last;
  } w_beat_t;

  // One translation decision, accept/save/drop are one-hot
  typedef struct packed {
    logic                       prefetch;
    logic                       hit;
    logic [`AXI_ID_WIDTH-1:0]   id;
    logic                       master;
    logic                       accept;
    logic                       save;
    logic                       drop;
  } l1_decision_t;

  // Holds 0 up to L1_FIFO_DEPTH inclusive
  typedef logic [$clog2(`L1_FIFO_DEPTH+1)-1:0] save_cnt_t;

endpackage

`default_nettype wire

/* axi4_w_fifo.sv */
// Valid/ready FIFO without output register; ready_o also rises when full and the head pops
`default_nettype none

`include "axi4_w_defs.svh"

module axi4_w_fifo
  import axi4_w_pkg::*;
#(
  parameter type payload_t = w_beat_t,
  parameter int  DEPTH     = `W_FIFO_DEPTH
) (
  input  wire logic     axi4_aclk,
  input  wire logic     axi4_arstn,

  // Push side
  input  wire logic     valid_i,
  input  wire payload_t data_i,
  output      logic     ready_o,

  // Pop side
  output      logic     valid_o,
  output      payload_t data_o,
  input  wire logic     ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  assign valid_o = (count_q != '0);
  // A full buffer still takes a beat in the cycle its head leaves
  assign ready_o = (count_q != CNT_W'(DEPTH)) | ready_i;
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage array
  always_ff @(posedge axi4_aclk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

/* axi4_w_decision_queue.sv */
// Decision queue; requests must be one-hot and held until l1_done_o, which may fire as a full head pops
`default_nettype none

`include "axi4_w_defs.svh"

module axi4_w_decision_queue
  import axi4_w_pkg::*;
(
  input  wire logic                     axi4_aclk,
  input  wire logic                     axi4_arstn,

  // Decisions from the translation unit
  input  wire logic                     l1_accept_i,
  input  wire logic                     l1_save_i,
  input  wire logic                     l1_drop_i,
  input  wire logic                     l1_master_i,
  input  wire logic                     l1_prefetch_i,
  input  wire logic                     l1_hit_i,
  input  wire logic [`AXI_ID_WIDTH-1:0] l1_id_i,
  output      logic                     l1_done_o,
  output      logic                     input_stall_o,
  output      logic                     output_stall_o,

  // Head towards the controller
  output      logic                     head_valid_o,
  output      l1_decision_t             head_o,
  input  wire logic                     head_pop_i
);

  l1_decision_t dec_in;
  logic         req;
  logic         fifo_ready;
  logic         push;
  logic         pop;
  logic         save_in;
  logic         save_out;
  save_cnt_t    dec_cnt_q;
  save_cnt_t    save_cnt_q;

  assign dec_in = '{prefetch: l1_prefetch_i, hit: l1_hit_i, id: l1_id_i,
                    master: l1_master_i, accept: l1_accept_i,
                    save: l1_save_i, drop: l1_drop_i};

  assign req  = l1_accept_i | l1_save_i | l1_drop_i;
  assign push = req & fifo_ready;
  assign pop  = head_valid_o & head_pop_i;

  assign l1_done_o = push;

  axi4_w_fifo #(
    .payload_t ( l1_decision_t  ),
    .DEPTH     ( `L1_FIFO_DEPTH )
  ) u_l1_fifo (
    .axi4_aclk  ( axi4_aclk    ),
    .axi4_arstn ( axi4_arstn   ),
    .valid_i    ( push         ),
    .data_i     ( dec_in       ),
    .ready_o    ( fifo_ready   ),
    .valid_o    ( head_valid_o ),
    .data_o     ( head_o       ),
    .ready_i    ( head_pop_i   )
  );

  // Save decisions entering and leaving the queue
  assign save_in  = push & l1_save_i;
  assign save_out = pop & head_o.save;

  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      dec_cnt_q  <= '0;
      save_cnt_q <= '0;
    end else begin
      if (push && !pop) begin
        dec_cnt_q <= dec_cnt_q + 1'b1;
      end else if (pop && !push) begin
        dec_cnt_q <= dec_cnt_q - 1'b1;
      end
      if (save_in && !save_out) begin
        save_cnt_q <= save_cnt_q + 1'b1;
      end else if (save_out && !save_in) begin
        save_cnt_q <= save_cnt_q - 1'b1;
      end
    end
  end

  assign input_stall_o  = (dec_cnt_q == save_cnt_t'(`L1_FIFO_DEPTH));
  // More than one pending save would need the second-level path
  assign output_stall_o = (save_cnt_q > save_cnt_t'(1));

endmodule

`default_nettype wire

/* axi4_w_forward_ctrl.sv */
// Burst router; assumes decisions and bursts arrive in the same order, one decision per burst
`default_nettype none

`include "axi4_w_defs.svh"

module axi4_w_forward_ctrl
  import axi4_w_pkg::*;
(
  input  wire logic                     axi4_aclk,
  input  wire logic                     axi4_arstn,

  // Beat FIFO head
  input  wire logic                     beat_valid_i,
  input  wire w_beat_t                  beat_i,
  output      logic                     beat_ready_o,

  // Decision queue head
  input  wire logic                     head_valid_i,
  input  wire l1_decision_t             head_i,
  output      logic                     head_pop_o,

  // W master side
  output      logic                     m_axi4_wvalid_o,
  output      w_beat_t                  m_axi4_w_o,
  input  wire logic                     m_axi4_wready_i,
  output      logic                     master_select_o,

  // B sender handshake
  output      logic                     b_drop_o,
  input  wire logic                     b_done_i,
  output      logic [`AXI_ID_WIDTH-1:0] id_o,
  output      logic                     prefetch_o,
  output      logic                     hit_o
);

  logic fwd_mode;
  logic sink_mode;
  logic fwd_last;
  logic sink_last;
  logic b_drop_q;

  // Save is treated like drop without a second translation level
  assign fwd_mode  = head_valid_i & head_i.accept;
  assign sink_mode = head_valid_i & ~head_i.accept & ~b_drop_q;

  assign m_axi4_wvalid_o = fwd_mode & beat_valid_i;
  assign m_axi4_w_o      = beat_i;
  assign master_select_o = head_i.master;

  always_comb begin
    beat_ready_o = 1'b0;
    if (fwd_mode) begin
      beat_ready_o = m_axi4_wready_i;
    end else if (sink_mode) begin
      beat_ready_o = 1'b1;
    end
  end

  assign fwd_last  = m_axi4_wvalid_o & m_axi4_wready_i & beat_i.last;
  assign sink_last = sink_mode & beat_valid_i & beat_i.last;

  // Drop request stays up until the B sender answers
  always_ff @(posedge axi4_aclk or negedge axi4_arstn) begin
    if (!axi4_arstn) begin
      b_drop_q <= 1'b0;
    end else if (b_drop_q && b_done_i) begin
      b_drop_q <= 1'b0;
    end else if (sink_last) begin
      b_drop_q <= 1'b1;
    end
  end

  assign b_drop_o   = b_drop_q;
  assign head_pop_o = fwd_last | (b_drop_q & b_done_i);

  assign id_o       = head_i.id;
  assign prefetch_o = head_i.prefetch;
  assign hit_o      = head_i.hit;

endmodule

`default_nettype wire

/* axi4_w_buffer.sv */
// W channel buffer top; no second TLB level, so save decisions are dropped like drop decisions
`default_nettype none

`include "axi4_w_defs.svh"

module axi4_w_buffer
  import axi4_w_pkg::*;
(
  input  wire logic                         axi4_aclk,
  input  wire logic                         axi4_arstn,

  // W slave side
  input  wire logic [`AXI_DATA_WIDTH-1:0]   s_axi4_wdata_i,
  input  wire logic [`AXI_DATA_WIDTH/8-1:0] s_axi4_wstrb_i,
  input  wire logic [`AXI_USER_WIDTH-1:0]   s_axi4_wuser_i,
  input  wire logic                         s_axi4_wlast_i,
  input  wire logic                         s_axi4_wvalid_i,
  output      logic                         s_axi4_wready_o,

  // W master side
  output      logic [`AXI_DATA_WIDTH-1:0]   m_axi4_wdata_o,
  output      logic [`AXI_DATA_WIDTH/8-1:0] m_axi4_wstrb_o,
  output      logic [`AXI_USER_WIDTH-1:0]   m_axi4_wuser_o,
  output      logic                         m_axi4_wlast_o,
  output      logic                         m_axi4_wvalid_o,
  input  wire logic                         m_axi4_wready_i,

  // Translation decisions
  input  wire logic                         l1_accept_i,
  input  wire logic                         l1_save_i,
  input  wire logic                         l1_drop_i,
  input  wire logic                         l1_master_i,
  input  wire logic                         l1_prefetch_i,
  input  wire logic                         l1_hit_i,
  input  wire logic [`AXI_ID_WIDTH-1:0]     l1_id_i,
  output      logic                         l1_done_o,
  output      logic                         input_stall_o,
  output      logic                         output_stall_o,
  output      logic                         master_select_o,

  // B sender
  output      logic                         b_drop_o,
  input  wire logic                         b_done_i,
  output      logic [`AXI_ID_WIDTH-1:0]     id_o,
  output      logic                         prefetch_o,
  output      logic                         hit_o
);

  w_beat_t      s_beat;
  w_beat_t      m_beat;
  w_beat_t      beat;
  logic         beat_valid;
  logic         beat_ready;
  l1_decision_t head;
  logic         head_valid;
  logic         head_pop;

  assign s_beat = '{data: s_axi4_wdata_i, strb: s_axi4_wstrb_i,
                    user: s_axi4_wuser_i, last: s_axi4_wlast_i};

  assign m_axi4_wdata_o = m_beat.data;
  assign m_axi4_wstrb_o = m_beat.strb;
  assign m_axi4_wuser_o = m_beat.user;
  assign m_axi4_wlast_o = m_beat.last;

  axi4_w_fifo #(
    .payload_t ( w_beat_t      ),
    .DEPTH     ( `W_FIFO_DEPTH )
  ) u_beat_fifo (
    .axi4_aclk  ( axi4_aclk       ),
    .axi4_arstn ( axi4_arstn      ),
    .valid_i    ( s_axi4_wvalid_i ),
    .data_i     ( s_beat          ),
    .ready_o    ( s_axi4_wready_o ),
    .valid_o    ( beat_valid      ),
    .data_o     ( beat            ),
    .ready_i    ( beat_ready      )
  );

  axi4_w_decision_queue u_decision_queue (
    .axi4_aclk      ( axi4_aclk      ),
    .axi4_arstn     ( axi4_arstn     ),
    .l1_accept_i    ( l1_accept_i    ),
    .l1_save_i      ( l1_save_i      ),
    .l1_drop_i      ( l1_drop_i      ),
    .l1_master_i    ( l1_master_i    ),
    .l1_prefetch_i  ( l1_prefetch_i  ),
    .l1_hit_i       ( l1_hit_i       ),
    .l1_id_i        ( l1_id_i        ),
    .l1_done_o      ( l1_done_o      ),
    .input_stall_o  ( input_stall_o  ),
    .output_stall_o ( output_stall_o ),
    .head_valid_o   ( head_valid     ),
    .head_o         ( head           ),
    .head_pop_i     ( head_pop       )
  );

  axi4_w_forward_ctrl u_forward_ctrl (
    .axi4_aclk       ( axi4_aclk       ),
    .axi4_arstn      ( axi4_arstn      ),
    .beat_valid_i    ( beat_valid      ),
    .beat_i          ( beat            ),
    .beat_ready_o    ( beat_ready      ),
    .head_valid_i    ( head_valid      ),
    .head_i          ( head            ),
    .head_pop_o      ( head_pop        ),
    .m_axi4_wvalid_o ( m_axi4_wvalid_o ),
    .m_axi4_w_o      ( m_beat          ),
    .m_axi4_wready_i ( m_axi4_wready_i ),
    .master_select_o ( master_select_o ),
    .b_drop_o        ( b_drop_o        ),
    .b_done_i        ( b_done_i        ),
    .id_o            ( id_o            ),
    .prefetch_o      ( prefetch_o      ),
    .hit_o           ( hit_o           )
  );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Free-running testbench clock that starts low; the period is a parameter in simulator time units
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD = 100
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

/* tb_axi4_w_buffer.sv */
// Random W traffic checked against a queue model; the seed is fixed, so every run repeats its stimulus
`default_nettype none

`include "axi4_w_defs.svh"

module tb_axi4_w_buffer
  import axi4_w_pkg::*;
();

  localparam int RAND_BURSTS = 40;
  localparam int BP_BURSTS   = 8;
  localparam int BP_CYCLES   = 40;
  localparam int FILL_BURSTS = 2 * `L1_FIFO_DEPTH;
  // At most four beats and one decision per burst
  localparam int TIMEOUT_CYCLES = 20 * 5 * (RAND_BURSTS + BP_BURSTS + FILL_BURSTS) + 200;

  logic                         axi4_aclk;
  logic                         axi4_arstn;
  logic [`AXI_DATA_WIDTH-1:0]   s_wdata, m_wdata;
  logic [`AXI_DATA_WIDTH/8-1:0] s_wstrb, m_wstrb;
  logic [`AXI_USER_WIDTH-1:0]   s_wuser, m_wuser;
  logic                         s_wlast, s_wvalid, s_wready;
  logic                         m_wlast, m_wvalid, m_wready;
  logic                         l1_accept, l1_save, l1_drop;
  logic                         l1_master, l1_prefetch, l1_hit;
  logic [`AXI_ID_WIDTH-1:0]     l1_id, id;
  logic                         l1_done, input_stall, output_stall, master_sel;
  logic                         b_drop, b_done, prefetch, hit;

  // Stimulus lists and the model of what the DUT holds
  w_beat_t      tx_beats[$];
  w_beat_t      exp_beats[$];
  l1_decision_t tx_decs[$];
  l1_decision_t dec_q[$];
  int           s_idx, d_idx, bursts_sent, save_cnt;
  bit           s_hold, d_hold, prev_drop, drop_seen, full_seen;
  int           err_cnt, tests_run, tests_failed, cycle_cnt;

  tb_clk_gen #(.PERIOD(100)) u_clk_gen (.clk_o(axi4_aclk));

  axi4_w_buffer axi4_w_buffer_i (
    .axi4_aclk       ( axi4_aclk    ),
    .axi4_arstn      ( axi4_arstn   ),
    .s_axi4_wdata_i  ( s_wdata      ),
    .s_axi4_wstrb_i  ( s_wstrb      ),
    .s_axi4_wuser_i  ( s_wuser      ),
    .s_axi4_wlast_i  ( s_wlast      ),
    .s_axi4_wvalid_i ( s_wvalid     ),
    .s_axi4_wready_o ( s_wready     ),
    .m_axi4_wdata_o  ( m_wdata      ),
    .m_axi4_wstrb_o  ( m_wstrb      ),
    .m_axi4_wuser_o  ( m_wuser      ),
    .m_axi4_wlast_o  ( m_wlast      ),
    .m_axi4_wvalid_o ( m_wvalid     ),
    .m_axi4_wready_i ( m_wready     ),
    .l1_accept_i     ( l1_accept    ),
    .l1_save_i       ( l1_save      ),
    .l1_drop_i       ( l1_drop      ),
    .l1_master_i     ( l1_master    ),
    .l1_prefetch_i   ( l1_prefetch  ),
    .l1_hit_i        ( l1_hit       ),
    .l1_id_i         ( l1_id        ),
    .l1_done_o       ( l1_done      ),
    .input_stall_o   ( input_stall  ),
    .output_stall_o  ( output_stall ),
    .master_select_o ( master_sel   ),
    .b_drop_o        ( b_drop       ),
    .b_done_i        ( b_done       ),
    .id_o            ( id           ),
    .prefetch_o      ( prefetch     ),
    .hit_o           ( hit          )
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("error %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    err_cnt++;
  endtask

  task automatic make_bursts(input int n, input bit accept_only);
    w_beat_t      b;
    l1_decision_t d;
    int           len;
    int           kind;
    tx_beats.delete();
    tx_decs.delete();
    for (int i = 0; i < n; i++) begin
      len = 1 + $urandom % 4;
      for (int k = 0; k < len; k++) begin
        b.data = $urandom;
        b.strb = (`AXI_DATA_WIDTH/8)'($urandom);
        b.user = `AXI_USER_WIDTH'($urandom);
        b.last = (k == len - 1);
        tx_beats.push_back(b);
      end
      kind       = accept_only ? 0 : $urandom % 3;
      d.accept   = (kind == 0);
      d.save     = (kind == 1);
      d.drop     = (kind == 2);
      d.id       = `AXI_ID_WIDTH'($urandom);
      d.master   = 1'($urandom);
      d.prefetch = 1'($urandom);
      d.hit      = 1'($urandom);
      tx_decs.push_back(d);
    end
  endtask

  // Model update from the values that the next rising edge will take
  task automatic sample_cycle(input bit hold_end);
    w_beat_t exp;
    bit      found;
    check_value("input_stall_o", input_stall, dec_q.size() == `L1_FIFO_DEPTH);
    if (dec_q.size() == `L1_FIFO_DEPTH) begin
      full_seen = 1'b1;
    end
    check_value("output_stall_o", output_stall, save_cnt > 1);
    if (!s_wready && exp_beats.size() < `W_FIFO_DEPTH) begin
      report_failure("slave ready dropped while the beat FIFO still had space");
    end
    if (hold_end) begin
      check_value("s_axi4_wready_o", s_wready, 0);
    end
    if (b_drop) begin
      if (dec_q.size() == 0 || dec_q[0].accept) begin
        report_failure("drop request raised without a save or drop decision at the head");
      end else begin
        check_value("id_o", id, dec_q[0].id);
        check_value("prefetch_o", prefetch, dec_q[0].prefetch);
        check_value("hit_o", hit, dec_q[0].hit);
        if (!prev_drop) begin
          if (drop_seen) begin
            report_failure("drop request raised twice for one decision");
          end
          drop_seen = 1'b1;
          // The sunk burst leaves the model here
          found = 1'b0;
          while (!found && exp_beats.size() > 0) begin
            exp   = exp_beats.pop_front();
            found = exp.last;
          end
          if (!found) begin
            report_failure("drop request raised before its whole burst had arrived");
          end
        end
      end
    end
    if (m_wvalid && m_wready) begin
      if (dec_q.size() == 0 || !dec_q[0].accept || exp_beats.size() == 0) begin
        report_failure("beat forwarded without an accepted burst at the head");
      end else begin
        exp = exp_beats.pop_front();
        check_value("m_axi4_wdata_o", m_wdata, exp.data);
        check_value("m_axi4_wstrb_o", m_wstrb, exp.strb);
        check_value("m_axi4_wuser_o", m_wuser, exp.user);
        check_value("m_axi4_wlast_o", m_wlast, exp.last);
        check_value("master_select_o", master_sel, dec_q[0].master);
        if (exp.last) begin
          dec_q.delete(0);
        end
      end
    end
    if (b_drop && b_done) begin
      if (dec_q.size() > 0 && !dec_q[0].accept) begin
        if (dec_q[0].save) begin
          save_cnt--;
        end
        dec_q.delete(0);
      end
      drop_seen = 1'b0;
    end
    if (s_wvalid && s_wready) begin
      exp_beats.push_back(tx_beats[s_idx]);
      if (tx_beats[s_idx].last) begin
        bursts_sent++;
      end
      s_idx++;
      s_hold = 1'b0;
    end
    if (l1_done) begin
      if (!d_hold) begin
        report_failure("decision done seen without a pending request");
      end else begin
        dec_q.push_back(tx_decs[d_idx]);
        if (tx_decs[d_idx].save) begin
          save_cnt++;
        end
        d_idx++;
        d_hold = 1'b0;
      end
    end
    prev_drop = b_drop;
  endtask

  task automatic run_traffic(input int hold_cycles, input bit dec_ahead);
    int bp;
    bp          = hold_cycles;
    s_idx       = 0;
    d_idx       = 0;
    bursts_sent = 0;
    s_hold      = 1'b0;
    d_hold      = 1'b0;
    drop_seen   = 1'b0;
    while (!(s_idx == tx_beats.size() && d_idx == tx_decs.size() &&
             dec_q.size() == 0 && exp_beats.size() == 0)) begin
      @(negedge axi4_aclk);
      // With decisions running ahead the beats wait until the decision queue is full
      if (!s_hold && s_idx < tx_beats.size() && $urandom % 5 != 0 &&
          (!dec_ahead || d_idx >= `L1_FIFO_DEPTH)) begin
        {s_wdata, s_wstrb, s_wuser, s_wlast} = tx_beats[s_idx];
        s_hold = 1'b1;
      end
      s_wvalid = s_hold;
      // Decisions stay one ahead of the bursts unless they run ahead
      if (!d_hold && d_idx < tx_decs.size() && (dec_ahead || d_idx <= bursts_sent) &&
          $urandom % 3 != 0) begin
        d_hold = 1'b1;
      end
      if (d_hold) begin
        {l1_prefetch, l1_hit, l1_id, l1_master} = {tx_decs[d_idx].prefetch,
          tx_decs[d_idx].hit, tx_decs[d_idx].id, tx_decs[d_idx].master};
        {l1_accept, l1_save, l1_drop} = {tx_decs[d_idx].accept, tx_decs[d_idx].save,
          tx_decs[d_idx].drop};
      end else begin
        {l1_accept, l1_save, l1_drop} = 3'b000;
      end
      m_wready = (bp > 0) ? 1'b0 : ($urandom % 4 != 0);
      b_done   = b_drop & 1'($urandom);
      #25;
      sample_cycle(bp == 1);
      if (bp > 0) begin
        bp--;
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt != errs_before) begin
      tests_failed++;
    end
    $display("test %s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  always @(posedge axi4_aclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    int errs;
    void'($urandom(32'h318));
    {s_wdata, s_wstrb, s_wuser, s_wlast, s_wvalid, m_wready} = '0;
    {l1_accept, l1_save, l1_drop, l1_master, l1_prefetch, l1_hit, l1_id, b_done} = '0;
    axi4_arstn = 1'b0;
    repeat (4) @(negedge axi4_aclk);
    axi4_arstn = 1'b1;
    @(negedge axi4_aclk);
    #25;
    errs = err_cnt;
    check_value("s_axi4_wready_o", s_wready, 1);
    check_value("m_axi4_wvalid_o", m_wvalid, 0);
    check_value("b_drop_o", b_drop, 0);
    check_value("l1_done_o", l1_done, 0);
    check_value("input_stall_o", input_stall, 0);
    check_value("output_stall_o", output_stall, 0);
    finish_test("reset_values", errs);

    errs = err_cnt;
    make_bursts(RAND_BURSTS, 1'b0);
    run_traffic(0, 1'b0);
    finish_test("random_traffic", errs);

    // Accept decisions only so that the held head burst fills the beat FIFO
    errs = err_cnt;
    make_bursts(BP_BURSTS, 1'b1);
    run_traffic(BP_CYCLES, 1'b0);
    finish_test("master_backpressure", errs);

    // Decisions run ahead of their bursts until the decision queue is full
    errs      = err_cnt;
    full_seen = 1'b0;
    make_bursts(FILL_BURSTS, 1'b0);
    run_traffic(0, 1'b1);
    if (!full_seen) begin
      report_failure("decision queue never reached its full depth");
    end
    finish_test("decision_fill", errs);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
axi4_w_pkg.sv
axi4_w_fifo.sv
axi4_w_decision_queue.sv
axi4_w_forward_ctrl.sv
axi4_w_buffer.sv
tb_clk_gen.sv
tb_axi4_w_buffer.sv

/* Makefile */
.PHONY: simulate clean

simulate:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_axi4_w_buffer -Mdir build
	./build/Vtb_axi4_w_buffer > sim.log 2>&1; cat sim.log
	grep -q "TEST PASSED" sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf build sim.log
